/* tcdm_params.svh */
// ------------------------------
// widths and depths of the shared TCDM port
// ------------------------------

`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// initiator side
`define TCDM_NB_CHAN 4 // number of initiator channels
`define TCDM_UW      2 // id width, log2 of channel count

// data path
`define TCDM_DW 32 // data word
`define TCDM_AW 16 // word address
`define TCDM_BW 8  // one byte lane

// storage
`define TCDM_FIFO_DEPTH 4   // request and response FIFOs
`define TCDM_MEM_WORDS  256 // words in the single bank

`endif

/* tcdm_pkg.sv */
// ------------------------------
// request, response and channel id types
// ------------------------------

`include "tcdm_params.svh"

package tcdm_pkg;

  // channel number, doubles as transaction id
  typedef logic [`TCDM_UW-1:0] chan_id_t;

  // what an initiator presents, 53 bits
  typedef struct packed {
    logic [`TCDM_AW-1:0]          add;  // word address
    logic                         wen;  // active low, 1 = read
    logic [`TCDM_DW-1:0]          data; // write data
    logic [`TCDM_DW/`TCDM_BW-1:0] be;   // byte enables
  } tcdm_core_req_t;

  // request after the mux, tagged with its source channel
  typedef struct packed {
    tcdm_core_req_t core;
    chan_id_t       user; // id, reflected back as r_user
  } tcdm_req_t;

  // response from the bank, 35 bits
  typedef struct packed {
    logic [`TCDM_DW-1:0] r_data;
    logic                r_opc;  // 1 = address out of range
    chan_id_t            r_user; // routes the response back
  } tcdm_rsp_t;

endpackage

/* tcdm_fifo.sv */
// ------------------------------
// synchronous FIFO, payload set by type parameter
// ------------------------------

`include "tcdm_params.svh"

module tcdm_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = `TCDM_FIFO_DEPTH,
  localparam int unsigned PW   = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned LW   = $clog2(DEPTH + 1)
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear,     // flush, one cycle
  input  logic          push,
  input  T              push_data,
  output logic          full,
  input  logic          pop,
  output T              pop_data,  // head of the queue
  output logic          empty,
  output logic [LW-1:0] level      // current occupancy
);

  T              mem_q [DEPTH]; // payload storage
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [LW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  // pointer wrap at DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    logic [PW-1:0] nxt;
    nxt = (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    return nxt;
  endfunction

  assign full  = (count_q == LW'(DEPTH));
  assign empty = (count_q == '0);
  assign level = count_q;

  // overflow and underflow requests are dropped here
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign pop_data = mem_q[rd_ptr_q]; // head visible the cycle after the push

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear) begin
      wr_ptr_q <= '0; // empties in one cycle
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + LW'(do_push) - LW'(do_pop); // push and pop together keep level
    end
  end

  // payload written at the tail
  always_ff @(posedge clk_i) begin : storage
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data;
    end
  end

endmodule

/* tcdm_mux_ooo.sv */
// ------------------------------
// N-to-1 request mux with id tagging
// and response routing by r_user
// ------------------------------

`include "tcdm_params.svh"

module tcdm_mux_ooo
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = `TCDM_NB_CHAN
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear,
  input  logic                         priority_force,
  input  chan_id_t       [NB_CHAN-1:0] prio,        // forced order, prio[0] ranks highest
  input  logic           [NB_CHAN-1:0] in_req,
  input  tcdm_core_req_t [NB_CHAN-1:0] in_payload,
  output logic           [NB_CHAN-1:0] in_gnt,
  input  logic           [NB_CHAN-1:0] in_lrdy,
  output logic           [NB_CHAN-1:0] in_r_valid,
  output logic           [`TCDM_DW-1:0] in_r_data,  // shared by all channels
  output logic                         in_r_opc,
  output logic                         out_req,     // same event as the FIFO push
  output tcdm_req_t                    out_payload,
  input  logic                         out_full,
  input  tcdm_rsp_t                    rsp_head,
  input  logic                         rsp_empty,
  output logic                         rsp_pop
);

  chan_id_t rr_q;    // round-robin start point
  chan_id_t winner;
  logic     found;   // some channel requests
  logic     grant;
  logic     rsp_valid;

  // first requesting channel in candidate order wins
  always_comb begin : arbiter
    chan_id_t cand;
    winner = rr_q;
    found  = 1'b0;
    for (int k = 0; k < NB_CHAN; k++) begin
      cand = priority_force ? prio[k] : chan_id_t'((int'(rr_q) + k) % NB_CHAN);
      if (!found && in_req[cand]) begin
        winner = cand;
        found  = 1'b1;
      end
    end
  end

  // no grant while flushing or in reset, or the push would be lost
  assign grant   = found & ~out_full & ~clear & rst_ni;
  assign out_req = grant;

  // tag the winner with its own channel number
  assign out_payload.core = in_payload[winner];
  assign out_payload.user = winner;

  // counter steps once per grant, independent of who won
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (clear) begin
      rr_q <= '0;
    end else if (grant) begin
      rr_q <= (rr_q == chan_id_t'(NB_CHAN - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  assign rsp_valid = ~rsp_empty;
  assign in_r_data = rsp_head.r_data;
  assign in_r_opc  = rsp_head.r_opc;

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_chan
    assign in_gnt[i]     = grant & (winner == chan_id_t'(i));
    assign in_r_valid[i] = rsp_valid & (rsp_head.r_user == chan_id_t'(i)); // route by id
  end

  // head is held until the addressed channel is ready
  assign rsp_pop = rsp_valid & in_lrdy[rsp_head.r_user];

endmodule

/* tcdm_mem_bank.sv */
// ------------------------------
// single word bank, byte enables,
// credit-gated pop and id reflection
// ------------------------------

`include "tcdm_params.svh"

module tcdm_mem_bank
  import tcdm_pkg::*;
#(
  localparam int unsigned WORDS = `TCDM_MEM_WORDS,
  localparam int unsigned IW    = $clog2(WORDS),
  localparam int unsigned LW    = $clog2(`TCDM_FIFO_DEPTH + 1),
  localparam int unsigned NBE   = `TCDM_DW / `TCDM_BW
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear,
  input  tcdm_req_t     req_head,  // request FIFO head
  input  logic          req_empty,
  output logic          req_pop,
  input  logic [LW-1:0] rsp_level, // response FIFO occupancy
  output logic          rsp_push,
  output tcdm_rsp_t     rsp_data
);

  logic [`TCDM_DW-1:0] mem_q [WORDS];
  tcdm_core_req_t      head;
  tcdm_rsp_t           rsp_q;        // gives the 1-cycle latency
  logic                in_flight_q;  // one response on its way to the FIFO
  logic                credit_free;
  logic                in_range;
  logic [IW-1:0]       word_idx;

  assign head     = req_head.core;
  assign in_range = (head.add < `TCDM_AW'(WORDS));
  assign word_idx = head.add[IW-1:0];

  // room in the response FIFO for everything already committed
  assign credit_free = (int'(rsp_level) + int'(in_flight_q)) < `TCDM_FIFO_DEPTH;
  assign req_pop     = ~req_empty & credit_free & ~clear;

  always_ff @(posedge clk_i or negedge rst_ni) begin : flight
    if (!rst_ni) begin
      in_flight_q <= 1'b0;
    end else if (clear) begin
      in_flight_q <= 1'b0;
    end else begin
      in_flight_q <= req_pop; // response lands one cycle after the pop
    end
  end

  // memory array and response payload
  always_ff @(posedge clk_i) begin : mem_access
    if (req_pop) begin
      rsp_q.r_user <= req_head.user; // id reflected unchanged
      rsp_q.r_opc  <= ~in_range;
      rsp_q.r_data <= '0;            // writes and misses return zero
      if (in_range) begin
        if (head.wen) begin
          rsp_q.r_data <= mem_q[word_idx];
        end else begin
          for (int b = 0; b < NBE; b++) begin
            if (head.be[b]) begin
              mem_q[word_idx][b*`TCDM_BW +: `TCDM_BW] <= head.data[b*`TCDM_BW +: `TCDM_BW];
            end
          end
        end
      end
    end
  end

  assign rsp_push = in_flight_q;
  assign rsp_data = rsp_q;

endmodule

/* tcdm_subsystem.sv */
// ------------------------------
// top level: mux, request and response
// FIFOs, memory bank
// ------------------------------

`include "tcdm_params.svh"

module tcdm_subsystem
  import tcdm_pkg::*;
#(
  localparam int unsigned NB_CHAN = `TCDM_NB_CHAN,
  localparam int unsigned LW      = $clog2(`TCDM_FIFO_DEPTH + 1)
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear,
  input  logic                          priority_force,
  input  chan_id_t       [NB_CHAN-1:0]  prio,
  input  logic           [NB_CHAN-1:0]  req,
  output logic           [NB_CHAN-1:0]  gnt,
  input  logic           [NB_CHAN-1:0]  lrdy,
  input  tcdm_core_req_t [NB_CHAN-1:0]  payload,
  output logic           [NB_CHAN-1:0]  r_valid,
  output logic           [`TCDM_DW-1:0] r_data,
  output logic                          r_opc
);

  // mux to request FIFO
  logic      req_push;
  tcdm_req_t req_push_data;
  logic      req_full;

  // request FIFO to bank
  tcdm_req_t req_head;
  logic      req_empty;
  logic      req_pop;

  // bank to response FIFO and back to the mux
  logic          rsp_push;
  tcdm_rsp_t     rsp_push_data;
  logic [LW-1:0] rsp_level;
  tcdm_rsp_t     rsp_head;
  logic          rsp_empty;
  logic          rsp_pop;

  tcdm_mux_ooo #(
    .NB_CHAN(NB_CHAN)
  ) u_mux (
    .clk_i, .rst_ni, .clear, .priority_force, .prio,
    .in_req(req), .in_payload(payload), .in_gnt(gnt), .in_lrdy(lrdy),
    .in_r_valid(r_valid), .in_r_data(r_data), .in_r_opc(r_opc),
    .out_req(req_push), .out_payload(req_push_data), .out_full(req_full),
    .rsp_head, .rsp_empty, .rsp_pop
  );

  tcdm_fifo #(.T(tcdm_req_t), .DEPTH(`TCDM_FIFO_DEPTH)) u_req_fifo (
    .clk_i, .rst_ni, .clear,
    .push(req_push), .push_data(req_push_data), .full(req_full),
    .pop(req_pop), .pop_data(req_head), .empty(req_empty), .level()
  );

  tcdm_mem_bank u_bank (
    .clk_i, .rst_ni, .clear,
    .req_head, .req_empty, .req_pop,
    .rsp_level, .rsp_push, .rsp_data(rsp_push_data)
  );

  // bank credits keep pushes off a full response FIFO
  tcdm_fifo #(.T(tcdm_rsp_t), .DEPTH(`TCDM_FIFO_DEPTH)) u_rsp_fifo (
    .clk_i, .rst_ni, .clear,
    .push(rsp_push), .push_data(rsp_push_data), .full(),
    .pop(rsp_pop), .pop_data(rsp_head), .empty(rsp_empty), .level(rsp_level)
  );

endmodule

/* tcdm_subsystem_properties.sv */
// ------------------------------
// handshake assertions on the top-level ports
// ------------------------------

`include "tcdm_params.svh"

module tcdm_subsystem_properties #(
  parameter int unsigned NB_CHAN = `TCDM_NB_CHAN
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic [NB_CHAN-1:0]  req,
  input logic [NB_CHAN-1:0]  gnt,
  input logic [NB_CHAN-1:0]  lrdy,
  input logic [NB_CHAN-1:0]  r_valid,
  input logic [`TCDM_DW-1:0] r_data,
  input logic                r_opc
);

  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt))
    else $error("gnt has more than one bit set");

  // grant only to a requesting channel
  gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni) (gnt & ~req) == '0)
    else $error("gnt without matching req");

  r_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(r_valid))
    else $error("r_valid has more than one bit set");

  // response head held while the addressed channel is not ready
  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|(r_valid & ~lrdy)) |=> $stable(r_valid) && $stable(r_data) && $stable(r_opc))
    else $error("response changed before lrdy");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> (gnt == '0 && r_valid == '0))
    else $error("gnt or r_valid high during reset");

endmodule

bind tcdm_subsystem tcdm_subsystem_properties u_props (
  .clk_i, .rst_ni, .req, .gnt, .lrdy, .r_valid, .r_data, .r_opc
);

/* tcdm_subsystem_tb.sv */
// ------------------------------
// directed testbench for the shared TCDM port
// ------------------------------

`include "tcdm_params.svh"

module tcdm_subsystem_tb
  import tcdm_pkg::*;
();

  localparam int NB      = `TCDM_NB_CHAN;
  localparam int REGION  = 16;  // words per channel region
  localparam int IW      = $clog2(`TCDM_MEM_WORDS);
  localparam int TIMEOUT = 200; // cycles allowed per wait

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic                           clear;
  logic                           priority_force;
  chan_id_t       [NB-1:0]        prio;
  logic           [NB-1:0]        req;
  logic           [NB-1:0]        gnt;
  logic           [NB-1:0]        lrdy;
  tcdm_core_req_t [NB-1:0]        payload;
  logic           [NB-1:0]        r_valid;
  logic           [`TCDM_DW-1:0]  r_data;
  logic                           r_opc;

  tcdm_req_t           gnt_log [$]; // every grant, in grant order
  tcdm_rsp_t           rsp_log [$]; // every response taken by an initiator
  tcdm_rsp_t           exp_q [$];   // expected responses, bank order
  logic [`TCDM_DW-1:0] ref_mem [`TCDM_MEM_WORDS]; // reference memory
  logic [`TCDM_DW-1:0] words [NB][REGION];
  int                  gnt_rd   = 0;
  int                  rsp_rd   = 0;
  int                  rr_mark  = 0; // grant count at last reset or clear
  int                  errors   = 0;
  int                  timeouts = 0;
  int                  seed     = 32'h10d4;

  always #4 clk_i = ~clk_i; // period 8

  tcdm_subsystem tcdm_subsystem_inst (
    .clk_i, .rst_ni, .clear, .priority_force, .prio,
    .req, .gnt, .lrdy, .payload,
    .r_valid, .r_data, .r_opc
  );

  // outputs settle by the falling edge, transfers happen on the next rising one
  always @(negedge clk_i) begin : monitor
    tcdm_req_t g;
    tcdm_rsp_t r;
    for (int c = 0; c < NB; c++) begin
      if (gnt[c]) begin
        g.core = payload[c];
        g.user = chan_id_t'(c);
        gnt_log.push_back(g);
      end
      if (r_valid[c] && lrdy[c]) begin
        r.r_data = r_data;
        r.r_opc  = r_opc;
        r.r_user = chan_id_t'(c); // channel that raised r_valid
        rsp_log.push_back(r);
      end
    end
  end

  function automatic logic [`TCDM_DW-1:0] merge_bytes(input logic [`TCDM_DW-1:0] old_w,
                                                      input logic [`TCDM_DW-1:0] new_w,
                                                      input logic [3:0]          be);
    logic [`TCDM_DW-1:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8]; // enabled lanes take the new byte
      end
    end
    return w;
  endfunction

  task automatic compare_data(input logic [`TCDM_DW-1:0] got, input logic [`TCDM_DW-1:0] exp,
                              input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic compare_opc(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic compare_chan(input chan_id_t got, input chan_id_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s on channel %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // grants reach the single bank in grant order, so the model follows the log
  task automatic check_traffic();
    tcdm_req_t g;
    tcdm_rsp_t e;
    tcdm_rsp_t r;
    while (gnt_rd < gnt_log.size()) begin
      g = gnt_log[gnt_rd];
      gnt_rd++;
      e.r_user = g.user;
      e.r_opc  = (g.core.add >= `TCDM_AW'(`TCDM_MEM_WORDS)); // outside the bank
      e.r_data = '0;
      if (!e.r_opc && g.core.wen) begin
        e.r_data = ref_mem[g.core.add[IW-1:0]];
      end else if (!e.r_opc) begin
        ref_mem[g.core.add[IW-1:0]] = merge_bytes(ref_mem[g.core.add[IW-1:0]],
                                                  g.core.data, g.core.be);
      end
      exp_q.push_back(e);
    end
    while (rsp_rd < rsp_log.size()) begin
      r = rsp_log[rsp_rd];
      rsp_rd++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error at time %0t: response on channel %0d with no request", $time, r.r_user);
      end else begin
        e = exp_q.pop_front();
        compare_chan(r.r_user, e.r_user, "response");
        compare_data(r.r_data, e.r_data, "r_data");
        compare_opc(r.r_opc, e.r_opc, "r_opc");
      end
    end
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (rsp_log.size() != gnt_log.size() && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (rsp_log.size() != gnt_log.size()) begin
      timeouts++;
      $display("timed out waiting for responses in %s test", what);
    end
    @(posedge clk_i);
    check_traffic();
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni  <= 1'b1;
    rr_mark = gnt_log.size(); // counter back at 0
  endtask

  // hold req and payload until gnt is seen
  task automatic send(input int ch, input tcdm_core_req_t p);
    int n;
    n = 0;
    @(posedge clk_i);
    req[ch]     <= 1'b1;
    payload[ch] <= p;
    @(negedge clk_i);
    while (!gnt[ch] && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!gnt[ch]) begin
      timeouts++;
      $display("timed out waiting for gnt on channel %0d", ch);
    end
    @(posedge clk_i);
    req[ch] <= 1'b0;
  endtask

  task automatic run_channel(input int ch, input int n, input logic wr);
    tcdm_core_req_t p;
    for (int i = 0; i < n; i++) begin
      p.add  = `TCDM_AW'(ch * REGION + i); // own region
      p.wen  = ~wr;
      p.data = wr ? words[ch][i] : '0;
      p.be   = 4'hf;
      send(ch, p);
    end
  endtask

  task automatic write_then_read(input int ch);
    run_channel(ch, 4, 1'b1);
    run_channel(ch, 4, 1'b0);
  endtask

  task automatic release_after_stall(input int ch);
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
      quiet = (req != '0 && gnt == '0) ? quiet + 1 : 0; // pending but refused
    end
    if (quiet < 4) begin
      timeouts++;
      $display("timed out waiting for gnt to stall under back-pressure");
    end
    @(posedge clk_i);
    lrdy[ch] <= 1'b1;
  endtask

  task automatic test_byte_enables();
    tcdm_core_req_t p;
    p.add  = `TCDM_AW'(8'h80); // above every channel region
    p.wen  = 1'b0;
    p.data = $random(seed);
    p.be   = 4'hf;
    send(0, p);
    p.data = $random(seed);
    p.be   = 4'b0110; // middle bytes only
    send(0, p);
    p.wen = 1'b1;
    send(0, p);
    drain("byte enable");
  endtask

  task automatic test_routing();
    for (int c = 0; c < NB; c++) begin
      for (int i = 0; i < REGION; i++) begin
        words[c][i] = $random(seed);
      end
    end
    fork
      write_then_read(0);
      write_then_read(1);
      write_then_read(2);
      write_then_read(3);
    join
    drain("routing");
  endtask

  task automatic test_forced_priority();
    chan_id_t perm [NB];
    int       s;
    perm = '{2'd2, 2'd0, 2'd3, 2'd1};
    priority_force <= 1'b1;
    for (int k = 0; k < NB; k++) begin
      prio[k] <= perm[k]; // prio[0] ranks highest
    end
    s = gnt_log.size();
    // requests rise together with reset and wait it out
    fork
      reset_dut();
      run_channel(0, 1, 1'b0);
      run_channel(1, 1, 1'b0);
      run_channel(2, 1, 1'b0);
      run_channel(3, 1, 1'b0);
    join
    drain("forced priority");
    for (int k = 0; k < NB; k++) begin
      compare_chan(gnt_log[s+k].user, perm[k], "forced priority grant");
    end
    priority_force <= 1'b0;
  endtask

  task automatic test_round_robin();
    int s;
    s = gnt_log.size();
    fork
      run_channel(0, 4, 1'b0);
      run_channel(1, 4, 1'b0);
      run_channel(2, 4, 1'b0);
      run_channel(3, 4, 1'b0);
    join
    drain("round robin");
    // counter steps once per grant since the last reset or clear
    for (int j = s; j < s + 16; j++) begin
      compare_chan(gnt_log[j].user, chan_id_t'((j - rr_mark) % NB), "round-robin grant");
    end
  endtask

  task automatic test_back_pressure();
    @(posedge clk_i);
    lrdy[2] <= 1'b0;
    fork
      run_channel(0, 3, 1'b0);
      run_channel(1, 3, 1'b0);
      run_channel(2, 3, 1'b0);
      run_channel(3, 3, 1'b0);
      release_after_stall(2);
    join
    drain("back-pressure");
  endtask

  task automatic test_range_and_clear();
    tcdm_core_req_t p;
    int             s;
    p.add  = `TCDM_AW'(`TCDM_MEM_WORDS); // first word past the bank
    p.wen  = 1'b1;
    p.data = '0;
    p.be   = 4'hf;
    send(1, p);
    drain("out of range");
    @(posedge clk_i);
    clear <= 1'b1;
    @(posedge clk_i);
    clear   <= 1'b0;
    rr_mark = gnt_log.size();
    s       = gnt_log.size();
    fork
      run_channel(0, 1, 1'b0);
      run_channel(1, 1, 1'b0);
      run_channel(2, 1, 1'b0);
      run_channel(3, 1, 1'b0);
    join
    drain("clear");
    compare_chan(gnt_log[s].user, chan_id_t'(0), "first grant after clear");
  endtask

  initial begin : main
    rst_ni         = 1'b0;
    clear          = 1'b0;
    priority_force = 1'b0;
    prio           = '0;
    req            = '0;
    lrdy           = '1;
    payload        = '0;
    reset_dut();
    test_byte_enables();
    test_routing();
    test_forced_priority();
    test_round_robin();
    test_back_pressure();
    test_range_and_clear();
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* tcdm_subsystem.f */
+incdir+.
tcdm_pkg.sv
tcdm_fifo.sv
tcdm_mux_ooo.sv
tcdm_mem_bank.sv
tcdm_subsystem.sv
tcdm_subsystem_properties.sv
tcdm_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the TCDM subsystem testbench

TOOL  := verilator
TOP   := tcdm_subsystem_tb
FLIST := tcdm_subsystem.f
FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG) || \
	   ! grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)
